// File: WakeupPipeline.f
SchedulerPkg.sv
RecoveryPkg.sv
RecoveryControl.sv
WakeupLane.sv
WakeupGate.sv
WakeupPipeline.sv
WakeupPipelineTb.sv

// File: Bender.yml
package:
  name: wakeup_pipeline

sources:
  - SchedulerPkg.sv
  - RecoveryPkg.sv
  - RecoveryControl.sv
  - WakeupLane.sv
  - WakeupGate.sv
  - WakeupPipeline.sv
  - target: simulation
    files:
      - WakeupPipelineTb.sv

// File: WakeupPipelineTb.sv
// Table-driven testbench for the wakeup pipeline.
// Each table row is one clock cycle of stimulus plus the head outputs
// expected in that cycle. Compile with the sources in WakeupPipeline.f.

`default_nettype none

module WakeupPipelineTb;
    import SchedulerPkg::*;
    import RecoveryPkg::*;

    localparam int NumRows = 48;
    localparam int ResetTimeout = 20;

    logic clock;
    logic reset;
    logic stall;
    logic selected [IssueWidth];
    IssueQueueIndexPath selectedPtr [IssueWidth];
    IssueQueueOneHotPath selectedVector [IssueWidth];
    ActiveListIndexPath selectedActiveListPtr [IssueWidth];
    IssueQueueOneHotPath flushIqEntry;
    RecoveryCmd recoveryCmd;
    ActiveListIndexPath flushRangeHead;
    ActiveListIndexPath flushRangeTail;
    logic flushAllInsns;
    logic wakeup [IssueWidth];
    IssueQueueIndexPath wakeupPtr [IssueWidth];
    IssueQueueOneHotPath wakeupVector [IssueWidth];
    logic releaseEntry [IssueWidth];
    IssueQueueIndexPath releasePtr [IssueWidth];
    logic flushedOpExist;

    // Stimulus columns.
    logic rowStall [NumRows];
    logic rowSelected [NumRows][IssueWidth];
    IssueQueueIndexPath rowPtr [NumRows][IssueWidth];
    IssueQueueOneHotPath rowVector [NumRows][IssueWidth];
    ActiveListIndexPath rowAlPtr [NumRows][IssueWidth];
    IssueQueueOneHotPath rowFlushIq [NumRows];
    RecoveryCmd rowCmd [NumRows];
    ActiveListIndexPath rowHead [NumRows];
    ActiveListIndexPath rowTail [NumRows];
    logic rowFlushAll [NumRows];

    // Expected head outputs per row.
    logic expRelease [NumRows][IssueWidth];
    logic expWakeup [NumRows][IssueWidth];
    IssueQueueIndexPath expPtr [NumRows][IssueWidth];
    IssueQueueOneHotPath expVector [NumRows][IssueWidth];
    logic expWindow [NumRows];

    logic [15:0] lfsrState;
    int checkCount;
    int errorCount;
    int rowErrors;

    WakeupPipeline i_WakeupPipeline (
        .clock                 (clock),
        .reset                 (reset),
        .stall                 (stall),
        .selected              (selected),
        .selectedPtr           (selectedPtr),
        .selectedVector        (selectedVector),
        .selectedActiveListPtr (selectedActiveListPtr),
        .flushIqEntry          (flushIqEntry),
        .recoveryCmd           (recoveryCmd),
        .flushRangeHead        (flushRangeHead),
        .flushRangeTail        (flushRangeTail),
        .flushAllInsns         (flushAllInsns),
        .wakeup                (wakeup),
        .wakeupPtr             (wakeupPtr),
        .wakeupVector          (wakeupVector),
        .releaseEntry          (releaseEntry),
        .releasePtr            (releasePtr),
        .flushedOpExist        (flushedOpExist)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #2 reset = 1'b0;
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic nextRandomBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], nextRandomBit()};
        end
        return value;
    endfunction

    function automatic ActiveListIndexPath randomAlPtr();
        return ActiveListIndexPath'(randomBits($bits(ActiveListIndexPath)));
    endfunction

    task automatic clearTable();
        for (int r = 0; r < NumRows; r++) begin
            rowStall[r] = 1'b0;
            rowFlushIq[r] = '0;
            rowCmd[r] = RecoveryNone;
            rowHead[r] = '0;
            rowTail[r] = '0;
            rowFlushAll[r] = 1'b0;
            expWindow[r] = 1'b0;
            for (int lane = 0; lane < IssueWidth; lane++) begin
                rowSelected[r][lane] = 1'b0;
                rowPtr[r][lane] = '0;
                rowVector[r][lane] = '0;
                rowAlPtr[r][lane] = '0;
                expRelease[r][lane] = 1'b0;
                expWakeup[r][lane] = 1'b0;
                expPtr[r][lane] = '0;
                expVector[r][lane] = '0;
            end
        end
    endtask

    // A zero delay marks an op that never reaches the head.
    task automatic selectOp(input int row, input int lane, input ActiveListIndexPath alPtr,
                            input int delay, input logic wakes);
        IssueQueueIndexPath ptr;
        IssueQueueOneHotPath vector;
        ptr = IssueQueueIndexPath'(randomBits($bits(IssueQueueIndexPath)));
        vector = IssueQueueOneHotPath'(randomBits($bits(IssueQueueOneHotPath)));
        rowSelected[row][lane] = 1'b1;
        rowPtr[row][lane] = ptr;
        rowVector[row][lane] = vector;
        rowAlPtr[row][lane] = alPtr;
        if (delay > 0) begin
            expRelease[row + delay][lane] = 1'b1;
            expWakeup[row + delay][lane] = wakes;
            expPtr[row + delay][lane] = ptr;
            expVector[row + delay][lane] = wakes ? vector : '0;
        end
    endtask

    task automatic openWindow(input int row, input ActiveListIndexPath head,
                              input ActiveListIndexPath tail, input logic all);
        rowCmd[row] = RecoverySelective;
        rowHead[row] = head;
        rowTail[row] = tail;
        rowFlushAll[row] = all;
        for (int r = row + 1; r <= row + IssueLatency; r++) begin
            expWindow[r] = 1'b1;
        end
    endtask

    task automatic buildTable();
        clearTable();
        // Back-to-back selections on every lane.
        for (int r = 2; r < 5; r++) begin
            for (int lane = 0; lane < IssueWidth; lane++) begin
                selectOp(r, lane, randomAlPtr(), IssueLatency, 1'b1);
            end
        end
        // Entry flushed in the cycle it is selected.
        selectOp(8, 0, randomAlPtr(), 0, 1'b0);
        rowFlushIq[8] = IssueQueueOneHotPath'(1) << rowPtr[8][0];
        // These ops sit at the head when the stall starts, so the bubble must replace them.
        for (int lane = 1; lane < IssueWidth; lane++) begin
            selectOp(8, lane, randomAlPtr(), IssueLatency, 1'b1);
            rowPtr[8][lane] = rowPtr[8][0] + IssueQueueIndexPath'(lane);
            expPtr[8 + IssueLatency][lane] = rowPtr[8][lane];
        end
        // The op in the entry stage waits one cycle and stalled selections are lost.
        for (int lane = 0; lane < IssueWidth; lane++) begin
            selectOp(9, lane, randomAlPtr(), IssueLatency + 1, 1'b1);
            selectOp(10, lane, randomAlPtr(), 0, 1'b0);
        end
        rowStall[10] = 1'b1;
        // Full recovery drops every op still in the lanes.
        for (int lane = 0; lane < IssueWidth; lane++) begin
            selectOp(16, lane, randomAlPtr(), 0, 1'b0);
            selectOp(17, lane, randomAlPtr(), 0, 1'b0);
        end
        rowCmd[17] = RecoveryFull;
        // Plain range 5 to 15.
        selectOp(22, 0, 5'd3, IssueLatency, 1'b1);
        selectOp(22, 1, 5'd8, IssueLatency, 1'b0);
        selectOp(22, 2, 5'd12, IssueLatency, 1'b0);
        selectOp(22, 3, 5'd20, IssueLatency, 1'b1);
        openWindow(23, 5'd5, 5'd15, 1'b0);
        selectOp(23, 0, 5'd5, IssueLatency, 1'b0);
        selectOp(23, 1, 5'd15, IssueLatency, 1'b1);
        selectOp(23, 2, 5'd14, IssueLatency, 1'b0);
        selectOp(23, 3, 5'd4, IssueLatency, 1'b1);
        // Inside the old range but after the window has closed.
        selectOp(30, 0, 5'd8, IssueLatency, 1'b1);
        // Wrapped range 28 to 2.
        selectOp(34, 0, 5'd30, IssueLatency, 1'b0);
        selectOp(34, 1, 5'd1, IssueLatency, 1'b0);
        selectOp(34, 2, 5'd2, IssueLatency, 1'b1);
        selectOp(34, 3, 5'd10, IssueLatency, 1'b1);
        openWindow(35, 5'd28, 5'd2, 1'b0);
        // Flush of all instructions with an empty range.
        // A stall at the top count keeps the window open one cycle longer.
        for (int lane = 0; lane < IssueWidth; lane++) begin
            selectOp(40, lane, randomAlPtr(), IssueLatency, 1'b0);
            selectOp(41, lane, randomAlPtr(), IssueLatency + 1, 1'b0);
        end
        openWindow(41, 5'd0, 5'd0, 1'b1);
        rowStall[42] = 1'b1;
        expWindow[41 + IssueLatency + 1] = 1'b1;
    endtask

    task automatic applyRow(input int r);
        stall = rowStall[r];
        for (int lane = 0; lane < IssueWidth; lane++) begin
            selected[lane] = rowSelected[r][lane];
            selectedPtr[lane] = rowPtr[r][lane];
            selectedVector[lane] = rowVector[r][lane];
            selectedActiveListPtr[lane] = rowAlPtr[r][lane];
        end
        flushIqEntry = rowFlushIq[r];
        recoveryCmd = rowCmd[r];
        flushRangeHead = rowHead[r];
        flushRangeTail = rowTail[r];
        flushAllInsns = rowFlushAll[r];
    endtask

    task automatic checkStrobe(input string name, input logic got, input logic expected);
        checkCount++;
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkPtr(input string name, input IssueQueueIndexPath got,
                            input IssueQueueIndexPath expected);
        checkCount++;
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkVector(input string name, input IssueQueueOneHotPath got,
                               input IssueQueueOneHotPath expected);
        checkCount++;
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
            rowErrors++;
        end
    endtask

    task automatic checkRow(input int r);
        rowErrors = 0;
        for (int lane = 0; lane < IssueWidth; lane++) begin
            checkStrobe($sformatf("releaseEntry[%0d]", lane), releaseEntry[lane],
                        expRelease[r][lane]);
            checkStrobe($sformatf("wakeup[%0d]", lane), wakeup[lane], expWakeup[r][lane]);
            checkVector($sformatf("wakeupVector[%0d]", lane), wakeupVector[lane],
                        expVector[r][lane]);
            // Pointers only mean something while the head is valid.
            if (expRelease[r][lane]) begin
                checkPtr($sformatf("releasePtr[%0d]", lane), releasePtr[lane], expPtr[r][lane]);
                checkPtr($sformatf("wakeupPtr[%0d]", lane), wakeupPtr[lane], expPtr[r][lane]);
            end
        end
        checkStrobe("flushedOpExist", flushedOpExist, expWindow[r]);
        if (rowErrors == 0) begin
            $display("row %0d passed", r);
        end else begin
            $display("row %0d had %0d errors", r, rowErrors);
        end
    endtask

    initial begin
        int waited;
        lfsrState = 16'd95;
        checkCount = 0;
        errorCount = 0;
        rowErrors = 0;
        waited = 0;
        stall = 1'b0;
        flushIqEntry = '0;
        recoveryCmd = RecoveryNone;
        flushRangeHead = '0;
        flushRangeTail = '0;
        flushAllInsns = 1'b0;
        for (int lane = 0; lane < IssueWidth; lane++) begin
            selected[lane] = 1'b0;
            selectedPtr[lane] = '0;
            selectedVector[lane] = '0;
            selectedActiveListPtr[lane] = '0;
        end
        buildTable();

        while (reset !== 1'b0 && waited < ResetTimeout) begin
            @(posedge clock);
            waited++;
        end

        if (reset !== 1'b0) begin
            $display("reset was still asserted after %0d cycles", waited);
            $display("Test FAILED");
        end else begin
            for (int r = 0; r < NumRows; r++) begin
                @(posedge clock);
                #2;
                applyRow(r);
                #14;
                checkRow(r);
            end

            $display("rows %0d, checks %0d, errors %0d", NumRows, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: WakeupPipeline.sv
// Top level of the wakeup pipeline that follows issue-queue select.
// Tracks issued ops per lane, wakes their consumers and frees their entries
// IssueLatency cycles later, and reports a possible flushed op in flight.

`default_nettype none

module WakeupPipeline (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  logic selected [SchedulerPkg::IssueWidth],
    input  SchedulerPkg::IssueQueueIndexPath selectedPtr [SchedulerPkg::IssueWidth],
    input  SchedulerPkg::IssueQueueOneHotPath selectedVector [SchedulerPkg::IssueWidth],
    input  RecoveryPkg::ActiveListIndexPath selectedActiveListPtr [SchedulerPkg::IssueWidth],
    input  SchedulerPkg::IssueQueueOneHotPath flushIqEntry,
    input  RecoveryPkg::RecoveryCmd recoveryCmd,
    input  RecoveryPkg::ActiveListIndexPath flushRangeHead,
    input  RecoveryPkg::ActiveListIndexPath flushRangeTail,
    input  logic flushAllInsns,
    output logic wakeup [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueIndexPath wakeupPtr [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueOneHotPath wakeupVector [SchedulerPkg::IssueWidth],
    output logic releaseEntry [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueIndexPath releasePtr [SchedulerPkg::IssueWidth],
    output logic flushedOpExist
);
    import SchedulerPkg::*;
    import RecoveryPkg::*;

    logic laneClear;
    logic flushWindow;
    ActiveListIndexPath flushHead;
    ActiveListIndexPath flushTail;
    logic flushAll;

    logic headValid [IssueWidth];
    IssueQueueIndexPath headPtr [IssueWidth];
    IssueQueueOneHotPath headVector [IssueWidth];
    ActiveListIndexPath headActiveListPtr [IssueWidth];

    RecoveryControl i_RecoveryControl (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .recoveryCmd    (recoveryCmd),
        .flushRangeHead (flushRangeHead),
        .flushRangeTail (flushRangeTail),
        .flushAllInsns  (flushAllInsns),
        .laneClear      (laneClear),
        .flushWindow    (flushWindow),
        .flushHead      (flushHead),
        .flushTail      (flushTail),
        .flushAll       (flushAll)
    );

    for (genvar lane = 0; lane < IssueWidth; lane++) begin : lanes
        WakeupLane i_WakeupLane (
            .clock                 (clock),
            .reset                 (reset),
            .stall                 (stall),
            .laneClear             (laneClear),
            .selected              (selected[lane]),
            .selectedPtr           (selectedPtr[lane]),
            .selectedVector        (selectedVector[lane]),
            .selectedActiveListPtr (selectedActiveListPtr[lane]),
            .flushIqEntry          (flushIqEntry),
            .headValid             (headValid[lane]),
            .headPtr               (headPtr[lane]),
            .headVector            (headVector[lane]),
            .headActiveListPtr     (headActiveListPtr[lane])
        );
    end

    WakeupGate i_WakeupGate (
        .headValid         (headValid),
        .headPtr           (headPtr),
        .headVector        (headVector),
        .headActiveListPtr (headActiveListPtr),
        .flushWindow       (flushWindow),
        .flushHead         (flushHead),
        .flushTail         (flushTail),
        .flushAll          (flushAll),
        .wakeup            (wakeup),
        .wakeupPtr         (wakeupPtr),
        .wakeupVector      (wakeupVector),
        .releaseEntry      (releaseEntry),
        .releasePtr        (releasePtr)
    );

    // Level to the recovery manager.
    assign flushedOpExist = flushWindow;

endmodule

`default_nettype wire

// File: WakeupGate.sv
// Wakeup and release stage at the head of the issue lanes.
// Suppresses wakeup for head ops that fall in the selective flush range
// while the flush window is open. Release always follows the head valid.

`default_nettype none

module WakeupGate (
    input  logic headValid [SchedulerPkg::IssueWidth],
    input  SchedulerPkg::IssueQueueIndexPath headPtr [SchedulerPkg::IssueWidth],
    input  SchedulerPkg::IssueQueueOneHotPath headVector [SchedulerPkg::IssueWidth],
    input  RecoveryPkg::ActiveListIndexPath headActiveListPtr [SchedulerPkg::IssueWidth],
    input  logic flushWindow,
    input  RecoveryPkg::ActiveListIndexPath flushHead,
    input  RecoveryPkg::ActiveListIndexPath flushTail,
    input  logic flushAll,
    output logic wakeup [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueIndexPath wakeupPtr [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueOneHotPath wakeupVector [SchedulerPkg::IssueWidth],
    output logic releaseEntry [SchedulerPkg::IssueWidth],
    output SchedulerPkg::IssueQueueIndexPath releasePtr [SchedulerPkg::IssueWidth]
);
    import SchedulerPkg::*;
    import RecoveryPkg::*;

    logic flushed [IssueWidth];

    // Range is head inclusive to tail exclusive and may wrap.
    // Equal pointers mean an empty range.
    function automatic logic inFlushRange(
        input ActiveListIndexPath ptr,
        input ActiveListIndexPath head,
        input ActiveListIndexPath tail
    );
        if (head < tail) begin
            return (ptr >= head) && (ptr < tail);
        end else if (head > tail) begin
            return (ptr >= head) || (ptr < tail);
        end
        return 1'b0;
    endfunction

    always_comb begin
        for (int i = 0; i < IssueWidth; i++) begin
            flushed[i] = flushWindow &&
                (flushAll || inFlushRange(headActiveListPtr[i], flushHead, flushTail));
            wakeup[i]       = headValid[i] && !flushed[i];
            wakeupPtr[i]    = headPtr[i];
            wakeupVector[i] = wakeup[i] ? headVector[i] : '0;
            // Flushed entries are still freed.
            releaseEntry[i] = headValid[i];
            releasePtr[i]   = headPtr[i];
        end
    end

endmodule

`default_nettype wire

// File: WakeupLane.sv
// One issue lane of the wakeup pipeline.
// Carries each selected op from the entry stage to the head stage in
// IssueLatency cycles. Stage 0 is the head, stage IssueLatency-1 the entry.

`default_nettype none

module WakeupLane (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  logic laneClear,
    input  logic selected,
    input  SchedulerPkg::IssueQueueIndexPath selectedPtr,
    input  SchedulerPkg::IssueQueueOneHotPath selectedVector,
    input  RecoveryPkg::ActiveListIndexPath selectedActiveListPtr,
    input  SchedulerPkg::IssueQueueOneHotPath flushIqEntry,
    output logic headValid,
    output SchedulerPkg::IssueQueueIndexPath headPtr,
    output SchedulerPkg::IssueQueueOneHotPath headVector,
    output RecoveryPkg::ActiveListIndexPath headActiveListPtr
);
    import SchedulerPkg::*;
    import RecoveryPkg::*;

    logic entryValid;
    logic stageValid [IssueLatency];
    IssueQueueIndexPath stagePtr [IssueLatency];
    IssueQueueOneHotPath stageVector [IssueLatency];
    ActiveListIndexPath stageActiveListPtr [IssueLatency];

    // Drop ops whose entry is flushed in the cycle they are selected.
    assign entryValid = selected && !flushIqEntry[selectedPtr];

    always_ff @(posedge clock) begin
        if (reset || laneClear) begin
            for (int j = 0; j < IssueLatency; j++) begin
                stageValid[j] <= 1'b0;
            end
        end else if (!stall) begin
            for (int j = 1; j < IssueLatency; j++) begin
                stageValid[j-1] <= stageValid[j];
            end
            stageValid[IssueLatency-1] <= entryValid;
        end else begin
            // Entry stage holds, the rest drain and a bubble follows them.
            for (int j = 1; j < IssueLatency - 1; j++) begin
                stageValid[j-1] <= stageValid[j];
            end
            stageValid[IssueLatency-2] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            for (int j = 1; j < IssueLatency; j++) begin
                stagePtr[j-1]           <= stagePtr[j];
                stageVector[j-1]        <= stageVector[j];
                stageActiveListPtr[j-1] <= stageActiveListPtr[j];
            end
            stagePtr[IssueLatency-1]           <= selectedPtr;
            stageVector[IssueLatency-1]        <= selectedVector;
            stageActiveListPtr[IssueLatency-1] <= selectedActiveListPtr;
        end else begin
            for (int j = 1; j < IssueLatency - 1; j++) begin
                stagePtr[j-1]           <= stagePtr[j];
                stageVector[j-1]        <= stageVector[j];
                stageActiveListPtr[j-1] <= stageActiveListPtr[j];
            end
            stageVector[IssueLatency-2] <= '0;
        end
    end

    assign headValid         = stageValid[0];
    assign headPtr           = stagePtr[0];
    assign headVector        = stageVector[0];
    assign headActiveListPtr = stageActiveListPtr[0];

endmodule

`default_nettype wire

// File: RecoveryControl.sv
// Recovery controller for the wakeup pipeline.
// Turns the recovery command into a lane clear or a recorded flush range,
// and keeps the flush window open until the flushed ops have left the lanes.

`default_nettype none

module RecoveryControl (
    input  logic clock,
    input  logic reset,
    input  logic stall,
    input  RecoveryPkg::RecoveryCmd recoveryCmd,
    input  RecoveryPkg::ActiveListIndexPath flushRangeHead,
    input  RecoveryPkg::ActiveListIndexPath flushRangeTail,
    input  logic flushAllInsns,
    output logic laneClear,
    output logic flushWindow,
    output RecoveryPkg::ActiveListIndexPath flushHead,
    output RecoveryPkg::ActiveListIndexPath flushTail,
    output logic flushAll
);
    import SchedulerPkg::*;
    import RecoveryPkg::*;

    logic loadRange;
    FlushCountPath flushCount;

    // Command decode.
    always_comb begin
        laneClear = 1'b0;
        loadRange = 1'b0;
        case (recoveryCmd)
            RecoveryFull:      laneClear = 1'b1;
            RecoverySelective: loadRange = 1'b1;
            default: begin
                laneClear = 1'b0;
                loadRange = 1'b0;
            end
        endcase
    end

    // Flush range, only meaningful while the window is open.
    always_ff @(posedge clock) begin
        if (loadRange) begin
            flushHead <= flushRangeHead;
            flushTail <= flushRangeTail;
            flushAll  <= flushAllInsns;
        end
    end

    // The entry stage holds during a stall, so the top count waits for
    // a free cycle before it starts to drain.
    always_ff @(posedge clock) begin
        if (reset) begin
            flushCount <= '0;
        end else if (loadRange) begin
            flushCount <= FlushCountPath'(IssueLatency);
        end else if (flushCount == FlushCountPath'(IssueLatency)) begin
            if (!stall) begin
                flushCount <= flushCount - FlushCountPath'(1);
            end
        end else if (flushCount != '0) begin
            flushCount <= flushCount - FlushCountPath'(1);
        end
    end

    assign flushWindow = (flushCount != '0);

endmodule

`default_nettype wire

// File: RecoveryPkg.sv
// Recovery-related types for the wakeup pipeline.
// Holds the active-list pointer, the recovery command encoding and the
// flush-window counter type.

`default_nettype none

package RecoveryPkg;

    localparam int ActiveListEntries = 32;
    localparam int ActiveListIndexWidth = $clog2(ActiveListEntries);

    typedef logic [ActiveListIndexWidth-1:0] ActiveListIndexPath;

    // One-cycle command from the recovery manager.
    typedef enum logic [1:0] {
        RecoveryNone      = 2'b00,
        RecoveryFull      = 2'b01,
        RecoverySelective = 2'b10
    } RecoveryCmd;

    // Counts the stages that may still hold a flushed op.
    typedef logic [$clog2(SchedulerPkg::IssueLatency + 1)-1:0] FlushCountPath;

endpackage

`default_nettype wire

// File: SchedulerPkg.sv
// Issue-queue and issue-lane sizing for the wakeup pipeline.
// Imported by the RTL modules and the testbench wherever entry pointers,
// producer vectors or the lane count are needed.

`default_nettype none

package SchedulerPkg;

    // Issue queue.
    localparam int IssueQueueEntries = 16;
    localparam int IssueQueueIndexWidth = $clog2(IssueQueueEntries);

    // Pointer to one issue-queue entry.
    typedef logic [IssueQueueIndexWidth-1:0] IssueQueueIndexPath;

    // One bit per entry, used for producer vectors and flush masks.
    typedef logic [IssueQueueEntries-1:0] IssueQueueOneHotPath;

    // Number of identical issue lanes.
    localparam int IssueWidth = 4;

    // Cycles from select to wakeup, which is also the lane depth.
    // Must be 2 or more.
    localparam int IssueLatency = 2;

endpackage

`default_nettype wire
